// ==== alu_pipeline.f ====
+incdir+common
common/pipe_pkg.sv
logic/fetch_stage.sv
decode/decode_stage.sv
execute/forward_unit.sv
execute/execute_stage.sv
logic/alu_pipeline.sv
test/alu_pipeline_tb.sv

// ==== common/pipe_macros.svh ====
`ifndef PIPE_MACROS_SVH
`define PIPE_MACROS_SVH

// Datapath widths
`define PIPE_XLEN        32
`define PIPE_REG_ADDR_W  5

// Fetch addressing
`define PIPE_PC_STEP     32'd4
`define PIPE_RESET_PC    32'h0000_0000

// Major opcodes
`define PIPE_OP_RTYPE    6'h00
`define PIPE_OP_ADDI     6'h08
`define PIPE_OP_SLTI     6'h0A
`define PIPE_OP_ANDI     6'h0C
`define PIPE_OP_ORI      6'h0D
`define PIPE_OP_XORI     6'h0E

// R-type function codes
`define PIPE_FN_ADD      6'h20
`define PIPE_FN_SUB      6'h22
`define PIPE_FN_AND      6'h24
`define PIPE_FN_OR       6'h25
`define PIPE_FN_XOR      6'h26
`define PIPE_FN_SLT      6'h2A
`define PIPE_FN_SLTU     6'h2B

`endif

// ==== common/pipe_pkg.sv ====
`include "pipe_macros.svh"

package pipe_pkg;

  // Data, instruction and address word
  typedef logic [`PIPE_XLEN-1:0] word_t;

  // Register file index
  typedef logic [`PIPE_REG_ADDR_W-1:0] reg_addr_t;

  // Instruction fields
  typedef logic [5:0] opcode_t;
  typedef logic [5:0] funct_t;
  typedef logic [15:0] imm_t;

  // Operation carried from decode to execute
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU
  } alu_op_e;

endpackage

// ==== decode/decode_stage.sv ====
`include "pipe_macros.svh"

module decode_stage (
  input  logic                clock,
  input  logic                reset_i,
  input  pipe_pkg::word_t     if_inst_i,
  input  logic                if_valid_i,
  output pipe_pkg::reg_addr_t rfile_rd_addr1_o,
  output pipe_pkg::reg_addr_t rfile_rd_addr2_o,
  input  pipe_pkg::word_t     rfile_rd_data1_i,
  input  pipe_pkg::word_t     rfile_rd_data2_i,
  input  pipe_pkg::reg_addr_t wb_dest_i,
  input  logic                wb_dest_valid_i,
  input  pipe_pkg::word_t     wb_result_i,
  output pipe_pkg::alu_op_e   ex_alu_op_o,
  output pipe_pkg::word_t     ex_a_o,
  output pipe_pkg::word_t     ex_b_o,
  output pipe_pkg::reg_addr_t ex_a_reg_o,
  output pipe_pkg::reg_addr_t ex_b_reg_o,
  output logic                ex_a_from_reg_o,
  output logic                ex_b_from_reg_o,
  output pipe_pkg::reg_addr_t ex_dest_o,
  output logic                ex_dest_valid_o
);

  pipe_pkg::opcode_t   opcode;
  pipe_pkg::funct_t    funct;
  pipe_pkg::reg_addr_t rs;
  pipe_pkg::reg_addr_t rt;
  pipe_pkg::reg_addr_t rd;
  pipe_pkg::imm_t      imm;
  pipe_pkg::word_t     imm_ext;
  pipe_pkg::word_t     a_val;
  pipe_pkg::word_t     b_val;
  pipe_pkg::reg_addr_t dest;
  pipe_pkg::alu_op_e   alu_op;
  logic                known;
  logic                is_itype;
  logic                sext;

  assign opcode = if_inst_i[31:26];
  assign rs     = if_inst_i[25:21];
  assign rt     = if_inst_i[20:16];
  assign rd     = if_inst_i[15:11];
  assign funct  = if_inst_i[5:0];
  assign imm    = if_inst_i[15:0];

  always_comb begin
    known    = 1'b1;
    is_itype = 1'b1;
    sext     = 1'b0;
    alu_op   = pipe_pkg::ALU_ADD;
    case (opcode)
      `PIPE_OP_RTYPE: begin
        is_itype = 1'b0;
        case (funct)
          `PIPE_FN_ADD:  alu_op = pipe_pkg::ALU_ADD;
          `PIPE_FN_SUB:  alu_op = pipe_pkg::ALU_SUB;
          `PIPE_FN_AND:  alu_op = pipe_pkg::ALU_AND;
          `PIPE_FN_OR:   alu_op = pipe_pkg::ALU_OR;
          `PIPE_FN_XOR:  alu_op = pipe_pkg::ALU_XOR;
          `PIPE_FN_SLT:  alu_op = pipe_pkg::ALU_SLT;
          `PIPE_FN_SLTU: alu_op = pipe_pkg::ALU_SLTU;
          default:       known  = 1'b0;
        endcase
      end
      `PIPE_OP_ADDI: sext = 1'b1;
      `PIPE_OP_SLTI: begin
        sext   = 1'b1;
        alu_op = pipe_pkg::ALU_SLT;
      end
      `PIPE_OP_ANDI: alu_op = pipe_pkg::ALU_AND;
      `PIPE_OP_ORI:  alu_op = pipe_pkg::ALU_OR;
      `PIPE_OP_XORI: alu_op = pipe_pkg::ALU_XOR;
      default:       known  = 1'b0;
    endcase
  end

  assign imm_ext = sext ? {{(`PIPE_XLEN-16){imm[15]}}, imm} : {{(`PIPE_XLEN-16){1'b0}}, imm};
  assign dest    = is_itype ? rt : rd;

  assign rfile_rd_addr1_o = rs;
  assign rfile_rd_addr2_o = rt;

  // Register being written this cycle is not yet visible in the file
  assign a_val = (wb_dest_valid_i && wb_dest_i == rs) ? wb_result_i : rfile_rd_data1_i;
  assign b_val = (wb_dest_valid_i && wb_dest_i == rt) ? wb_result_i : rfile_rd_data2_i;

  always_ff @(posedge clock) begin
    if (reset_i) begin
      ex_dest_valid_o <= 1'b0;
      ex_a_from_reg_o <= 1'b0;
      ex_b_from_reg_o <= 1'b0;
    end else begin
      ex_dest_valid_o <= if_valid_i && known && (dest != '0);
      ex_a_from_reg_o <= if_valid_i && known;
      ex_b_from_reg_o <= if_valid_i && known && !is_itype;
    end
  end

  always_ff @(posedge clock) begin
    ex_alu_op_o <= alu_op;
    ex_a_o      <= a_val;
    ex_b_o      <= is_itype ? imm_ext : b_val;
    ex_a_reg_o  <= rs;
    ex_b_reg_o  <= rt;
    ex_dest_o   <= dest;
  end

endmodule

// ==== execute/execute_stage.sv ====
module execute_stage (
  input  logic                clock,
  input  logic                reset_i,
  input  pipe_pkg::alu_op_e   alu_op_i,
  input  pipe_pkg::word_t     alu_a_i,
  input  pipe_pkg::word_t     alu_b_i,
  input  pipe_pkg::reg_addr_t dest_i,
  input  logic                dest_valid_i,
  output pipe_pkg::reg_addr_t wb_dest_o,
  output logic                wb_dest_valid_o,
  output pipe_pkg::word_t     wb_result_o
);

  pipe_pkg::word_t result;

  always_comb begin
    result = alu_a_i + alu_b_i;
    case (alu_op_i)
      pipe_pkg::ALU_ADD: result = alu_a_i + alu_b_i;
      pipe_pkg::ALU_SUB: result = alu_a_i - alu_b_i;
      pipe_pkg::ALU_AND: result = alu_a_i & alu_b_i;
      pipe_pkg::ALU_OR:  result = alu_a_i | alu_b_i;
      pipe_pkg::ALU_XOR: result = alu_a_i ^ alu_b_i;
      pipe_pkg::ALU_SLT: begin
        result = ($signed(alu_a_i) < $signed(alu_b_i)) ? 'd1 : '0;
      end
      pipe_pkg::ALU_SLTU: begin
        result = (alu_a_i < alu_b_i) ? 'd1 : '0;
      end
      default: result = alu_a_i + alu_b_i;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset_i) begin
      wb_dest_valid_o <= 1'b0;
    end else begin
      wb_dest_valid_o <= dest_valid_i;
    end
  end

  always_ff @(posedge clock) begin
    wb_dest_o   <= dest_i;
    wb_result_o <= result;
  end

  // Decode filters out r0 destinations, so none may reach write-back
  no_r0_write_a: assert property (
    @(posedge clock) disable iff (reset_i)
    wb_dest_valid_o |-> (wb_dest_o != '0)
  );

endmodule

// ==== execute/forward_unit.sv ====
module forward_unit (
  input  pipe_pkg::word_t     ex_a_i,
  input  pipe_pkg::word_t     ex_b_i,
  input  pipe_pkg::reg_addr_t ex_a_reg_i,
  input  pipe_pkg::reg_addr_t ex_b_reg_i,
  input  logic                ex_a_from_reg_i,
  input  logic                ex_b_from_reg_i,
  input  pipe_pkg::reg_addr_t wb_dest_i,
  input  logic                wb_dest_valid_i,
  input  pipe_pkg::word_t     wb_result_i,
  output pipe_pkg::word_t     alu_a_o,
  output pipe_pkg::word_t     alu_b_o
);

  logic hit_a;
  logic hit_b;

  // Previous instruction still sits in EX/WB
  assign hit_a = ex_a_from_reg_i && wb_dest_valid_i && (wb_dest_i == ex_a_reg_i);
  assign hit_b = ex_b_from_reg_i && wb_dest_valid_i && (wb_dest_i == ex_b_reg_i);

  assign alu_a_o = hit_a ? wb_result_i : ex_a_i;
  assign alu_b_o = hit_b ? wb_result_i : ex_b_i;

endmodule

// ==== logic/alu_pipeline.sv ====
module alu_pipeline (
  input  logic                clock,
  input  logic                reset_i,

  // Instruction cache
  output pipe_pkg::word_t     icache_addr_o,
  output logic                icache_rd_o,
  input  pipe_pkg::word_t     icache_data_i,
  input  logic                icache_waitrequest_i,

  // Register file read
  output pipe_pkg::reg_addr_t rfile_rd_addr1_o,
  output pipe_pkg::reg_addr_t rfile_rd_addr2_o,
  input  pipe_pkg::word_t     rfile_rd_data1_i,
  input  pipe_pkg::word_t     rfile_rd_data2_i,

  // Register file write
  output pipe_pkg::reg_addr_t rfile_wr_addr_o,
  output logic                rfile_wr_enable_o,
  output pipe_pkg::word_t     rfile_wr_data_o
);

  // IF/ID
  pipe_pkg::word_t     if_inst;
  logic                if_valid;

  // ID/EX
  pipe_pkg::alu_op_e   ex_alu_op;
  pipe_pkg::word_t     ex_a;
  pipe_pkg::word_t     ex_b;
  pipe_pkg::reg_addr_t ex_a_reg;
  pipe_pkg::reg_addr_t ex_b_reg;
  logic                ex_a_from_reg;
  logic                ex_b_from_reg;
  pipe_pkg::reg_addr_t ex_dest;
  logic                ex_dest_valid;

  // Forwarded operands
  pipe_pkg::word_t     alu_a;
  pipe_pkg::word_t     alu_b;

  // EX/WB
  pipe_pkg::reg_addr_t wb_dest;
  logic                wb_dest_valid;
  pipe_pkg::word_t     wb_result;

  assign rfile_wr_addr_o   = wb_dest;
  assign rfile_wr_enable_o = wb_dest_valid;
  assign rfile_wr_data_o   = wb_result;

  fetch_stage fetch_i (
    .clock                (clock),
    .reset_i              (reset_i),
    .icache_waitrequest_i (icache_waitrequest_i),
    .icache_data_i        (icache_data_i),
    .icache_addr_o        (icache_addr_o),
    .icache_rd_o          (icache_rd_o),
    .if_inst_o            (if_inst),
    .if_valid_o           (if_valid)
  );

  decode_stage decode_i (
    .clock            (clock),
    .reset_i          (reset_i),
    .if_inst_i        (if_inst),
    .if_valid_i       (if_valid),
    .rfile_rd_addr1_o (rfile_rd_addr1_o),
    .rfile_rd_addr2_o (rfile_rd_addr2_o),
    .rfile_rd_data1_i (rfile_rd_data1_i),
    .rfile_rd_data2_i (rfile_rd_data2_i),
    .wb_dest_i        (wb_dest),
    .wb_dest_valid_i  (wb_dest_valid),
    .wb_result_i      (wb_result),
    .ex_alu_op_o      (ex_alu_op),
    .ex_a_o           (ex_a),
    .ex_b_o           (ex_b),
    .ex_a_reg_o       (ex_a_reg),
    .ex_b_reg_o       (ex_b_reg),
    .ex_a_from_reg_o  (ex_a_from_reg),
    .ex_b_from_reg_o  (ex_b_from_reg),
    .ex_dest_o        (ex_dest),
    .ex_dest_valid_o  (ex_dest_valid)
  );

  forward_unit forward_i (
    .ex_a_i          (ex_a),
    .ex_b_i          (ex_b),
    .ex_a_reg_i      (ex_a_reg),
    .ex_b_reg_i      (ex_b_reg),
    .ex_a_from_reg_i (ex_a_from_reg),
    .ex_b_from_reg_i (ex_b_from_reg),
    .wb_dest_i       (wb_dest),
    .wb_dest_valid_i (wb_dest_valid),
    .wb_result_i     (wb_result),
    .alu_a_o         (alu_a),
    .alu_b_o         (alu_b)
  );

  execute_stage execute_i (
    .clock           (clock),
    .reset_i         (reset_i),
    .alu_op_i        (ex_alu_op),
    .alu_a_i         (alu_a),
    .alu_b_i         (alu_b),
    .dest_i          (ex_dest),
    .dest_valid_i    (ex_dest_valid),
    .wb_dest_o       (wb_dest),
    .wb_dest_valid_o (wb_dest_valid),
    .wb_result_o     (wb_result)
  );

endmodule

// ==== logic/fetch_stage.sv ====
`include "pipe_macros.svh"

module fetch_stage (
  input  logic            clock,
  input  logic            reset_i,
  input  logic            icache_waitrequest_i,
  input  pipe_pkg::word_t icache_data_i,
  output pipe_pkg::word_t icache_addr_o,
  output logic            icache_rd_o,
  output pipe_pkg::word_t if_inst_o,
  output logic            if_valid_o
);

  pipe_pkg::word_t pc_q;
  logic            rd_q;
  logic            accept;

  // Word taken on this edge
  assign accept = rd_q && !icache_waitrequest_i;

  assign icache_addr_o = pc_q;
  assign icache_rd_o   = rd_q;

  always_ff @(posedge clock) begin
    if (reset_i) begin
      pc_q       <= `PIPE_RESET_PC;
      rd_q       <= 1'b0;
      if_valid_o <= 1'b0;
    end else begin
      rd_q       <= 1'b1;
      // Bubble into IF/ID while the cache holds us off
      if_valid_o <= accept;
      if (accept) begin
        pc_q <= pc_q + `PIPE_PC_STEP;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      if_inst_o <= icache_data_i;
    end
  end

  // Cache needs the address held until the word is delivered
  addr_hold_a: assert property (
    @(posedge clock) disable iff (reset_i)
    icache_waitrequest_i |=> $stable(icache_addr_o)
  );

endmodule

// ==== test/alu_pipeline_tb.sv ====
`include "pipe_macros.svh"

module alu_pipeline_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int clock_period = 40;
  localparam int drive_delay  = 2;
  localparam int reset_cycles = 8;
  localparam int num_insts    = 400;
  // About 4/3 cycles per instruction, so three per instruction covers reset and drain
  localparam int cycle_limit  = num_insts * 3;

  logic                clock;
  logic                reset_i;
  pipe_pkg::word_t     icache_addr_o;
  logic                icache_rd_o;
  pipe_pkg::word_t     icache_data_i;
  logic                icache_waitrequest_i;
  pipe_pkg::reg_addr_t rfile_rd_addr1_o;
  pipe_pkg::reg_addr_t rfile_rd_addr2_o;
  pipe_pkg::word_t     rfile_rd_data1_i;
  pipe_pkg::word_t     rfile_rd_data2_i;
  pipe_pkg::reg_addr_t rfile_wr_addr_o;
  logic                rfile_wr_enable_o;
  pipe_pkg::word_t     rfile_wr_data_o;

  pipe_pkg::word_t     program_mem [256];
  pipe_pkg::word_t     rf [32];
  pipe_pkg::word_t     model_regs [32];
  pipe_pkg::reg_addr_t exp_addr_q [$];
  pipe_pkg::word_t     exp_data_q [$];
  int                  exp_cycle_q [$];
  logic [31:0]         lcg_state = 32'd50;
  int                  cycle = 0;
  int                  accepts = 0;
  int                  post_reset = 0;
  pipe_pkg::word_t     next_pc = `PIPE_RESET_PC;
  pipe_pkg::word_t     last_addr;
  logic                held = 1'b0;

  alu_pipeline dut_i (.*);

  initial begin
    clock = 1'b0;
    forever #(clock_period / 2) clock = ~clock;
  end

  // Cache and register file models, guarded against unknown addresses
  assign icache_data_i = $isunknown(icache_addr_o) ? '0 : program_mem[icache_addr_o[9:2]];
  assign rfile_rd_data1_i = $isunknown(rfile_rd_addr1_o) ? '0 : rf[rfile_rd_addr1_o];
  assign rfile_rd_data2_i = $isunknown(rfile_rd_addr2_o) ? '0 : rf[rfile_rd_addr2_o];

  always @(posedge clock) begin
    if (rfile_wr_enable_o === 1'b1) begin
      rf[rfile_wr_addr_o] <= rfile_wr_data_o;
    end
  end

  function automatic logic [15:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[31:16];
  endfunction

  function automatic pipe_pkg::word_t random_inst();
    logic [5:0] fn_table [7] = '{`PIPE_FN_ADD, `PIPE_FN_SUB, `PIPE_FN_AND, `PIPE_FN_OR,
                                 `PIPE_FN_XOR, `PIPE_FN_SLT, `PIPE_FN_SLTU};
    logic [5:0] op_table [5] = '{`PIPE_OP_ADDI, `PIPE_OP_SLTI, `PIPE_OP_ANDI,
                                 `PIPE_OP_ORI, `PIPE_OP_XORI};
    logic [15:0] r;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    int          sel;
    r   = lcg_next();
    sel = r[3:0];
    // Registers 0 to 7 only, so neighbours often depend on each other
    rs  = {2'b00, r[6:4]};
    rt  = {2'b00, r[9:7]};
    rd  = {2'b00, r[12:10]};
    if (sel < 7) return {`PIPE_OP_RTYPE, rs, rt, rd, 5'd0, fn_table[sel]};
    if (sel < 12) return {op_table[sel - 7], rs, rt, lcg_next()};
    if (sel == 12) return {`PIPE_OP_RTYPE, rs, rt, rd, 5'd0, 6'h01};
    if (sel == 13) return {6'h23, rs, rt, lcg_next()};
    return {lcg_next(), lcg_next()};
  endfunction

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("=== FAIL ===");
    $fatal(1, "stopped at first error");
  endtask

  // Reference model, runs one accepted instruction and queues its write
  task automatic run_model(input pipe_pkg::word_t inst, input int acc_cycle);
    pipe_pkg::word_t     a;
    pipe_pkg::word_t     b;
    pipe_pkg::word_t     imm_s;
    pipe_pkg::word_t     imm_z;
    pipe_pkg::word_t     res;
    pipe_pkg::reg_addr_t dst;
    logic                ok;
    a     = model_regs[inst[25:21]];
    b     = model_regs[inst[20:16]];
    imm_s = {{16{inst[15]}}, inst[15:0]};
    imm_z = {16'd0, inst[15:0]};
    res   = '0;
    ok    = 1'b1;
    dst   = (inst[31:26] == `PIPE_OP_RTYPE) ? inst[15:11] : inst[20:16];
    case (inst[31:26])
      `PIPE_OP_RTYPE: begin
        case (inst[5:0])
          `PIPE_FN_ADD:  res = a + b;
          `PIPE_FN_SUB:  res = a - b;
          `PIPE_FN_AND:  res = a & b;
          `PIPE_FN_OR:   res = a | b;
          `PIPE_FN_XOR:  res = a ^ b;
          `PIPE_FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          `PIPE_FN_SLTU: res = (a < b) ? 32'd1 : 32'd0;
          default:       ok = 1'b0;
        endcase
      end
      `PIPE_OP_ADDI: res = a + imm_s;
      `PIPE_OP_SLTI: res = ($signed(a) < $signed(imm_s)) ? 32'd1 : 32'd0;
      `PIPE_OP_ANDI: res = a & imm_z;
      `PIPE_OP_ORI:  res = a | imm_z;
      `PIPE_OP_XORI: res = a ^ imm_z;
      default:       ok = 1'b0;
    endcase
    if (ok && dst != '0) begin
      model_regs[dst] = res;
      exp_addr_q.push_back(dst);
      exp_data_q.push_back(res);
      exp_cycle_q.push_back(acc_cycle + 3);
    end
  endtask

  task automatic check_write();
    assert (exp_addr_q.size() != 0)
      else stop_run($sformatf("register write to r%0d at %0t with no instruction pending",
                              rfile_wr_addr_o, $time));
    assert (rfile_wr_addr_o === exp_addr_q[0])
      else stop_run($sformatf("error at %0t: rfile_wr_addr_o = %0d, expected %0d",
                              $time, rfile_wr_addr_o, exp_addr_q[0]));
    assert (rfile_wr_data_o === exp_data_q[0])
      else stop_run($sformatf("error at %0t: rfile_wr_data_o = %h, expected %h",
                              $time, rfile_wr_data_o, exp_data_q[0]));
    assert (cycle == exp_cycle_q[0])
      else stop_run($sformatf("error at %0t: rfile_wr_enable_o cycle = %0d, expected %0d",
                              $time, cycle, exp_cycle_q[0]));
    void'(exp_addr_q.pop_front());
    void'(exp_data_q.pop_front());
    void'(exp_cycle_q.pop_front());
  endtask

  // Monitor at the falling edge, where every signal has settled
  always @(negedge clock) begin
    cycle++;
    assert (cycle < cycle_limit)
      else stop_run($sformatf("timeout: run not finished after %0d cycles", cycle));
    if (reset_i) begin
      assert (rfile_wr_enable_o === 1'b0)
        else stop_run($sformatf("error at %0t: rfile_wr_enable_o = %b, expected 0",
                                $time, rfile_wr_enable_o));
      assert (icache_rd_o === 1'b0)
        else stop_run($sformatf("error at %0t: icache_rd_o = %b, expected 0",
                                $time, icache_rd_o));
      held = 1'b0;
    end else begin
      post_reset++;
      if (post_reset <= 2) begin
        assert (rfile_wr_enable_o === 1'b0)
          else stop_run($sformatf("error at %0t: rfile_wr_enable_o = %b, expected 0",
                                  $time, rfile_wr_enable_o));
      end
      if (held) begin
        assert (icache_addr_o === last_addr)
          else stop_run($sformatf("error at %0t: icache_addr_o = %h, expected %h",
                                  $time, icache_addr_o, last_addr));
      end
      held      = icache_rd_o && icache_waitrequest_i;
      last_addr = icache_addr_o;
      if (rfile_wr_enable_o) check_write();
      if (icache_rd_o === 1'b1 && !icache_waitrequest_i) begin
        assert (icache_addr_o === next_pc)
          else stop_run($sformatf("error at %0t: icache_addr_o = %h, expected %h",
                                  $time, icache_addr_o, next_pc));
        run_model(program_mem[icache_addr_o[9:2]], cycle);
        next_pc = next_pc + `PIPE_PC_STEP;
        accepts++;
      end
    end
  end

  initial begin
    reset_i              = 1'b1;
    icache_waitrequest_i = 1'b0;
    for (int i = 0; i < 32; i++) begin
      rf[i]         = (i == 0) ? '0 : {lcg_next(), lcg_next()};
      model_regs[i] = rf[i];
    end
    for (int i = 0; i < 256; i++) begin
      program_mem[i] = random_inst();
    end
    repeat (reset_cycles) @(posedge clock);
    #drive_delay;
    reset_i = 1'b0;
    while (accepts < num_insts) begin
      icache_waitrequest_i = (lcg_next() % 4) == 0;
      @(posedge clock);
      #drive_delay;
    end
    // Hold the cache off so no instruction past the last one is taken
    icache_waitrequest_i = 1'b1;
    // Last write is due 3 cycles after the last accept
    repeat (4) @(posedge clock);
    assert (exp_addr_q.size() == 0) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      stop_run($sformatf("%0d expected writes never appeared", exp_addr_q.size()));
    end
  end

endmodule
